//--- verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// register and alu width
`define DATA_WIDTH      32
`define INSTR_WIDTH     32

// register file size
`define NUM_REGS        16
`define REG_IDX_BITS    4

// instruction memory size
`define IMEM_DEPTH      256
`define IMEM_ADDR_BITS  8

// instruction fields: op | rd | rn | rm/imm
`define OP_HI   31
`define OP_LO   28
`define RD_HI   27
`define RD_LO   24
`define RN_HI   23
`define RN_LO   20
`define RM_HI   19
`define RM_LO   16
`define IMM_HI  15
`define IMM_LO  0

// pc and every register start here
`define RESET_VALUE 0

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

   // register value and alu operand
   typedef logic [`DATA_WIDTH-1:0]     dataT;

   // raw instruction word
   typedef logic [`INSTR_WIDTH-1:0]    instrT;

   // register number
   typedef logic [`REG_IDX_BITS-1:0]   regIdxT;

   // instruction memory word address
   typedef logic [`IMEM_ADDR_BITS-1:0] imemAddrT;

   // opcodes, anything not listed runs as NOP
   typedef enum logic [`OP_HI-`OP_LO:0]
   {
      NOP  = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      ORR  = 4'd4,
      EOR  = 4'd5,
      ADDI = 4'd6,
      MOVI = 4'd7,
      HALT = 4'd15
   } opcodeT;

endpackage

//--- verilog/hostPort.sv
module hostPort
(
   input  logic               clock,
   input  logic               rstN_i,
   input  logic               hostReq_i,
   input  logic               hostWe_i,
   input  cpu_pkg::imemAddrT  hostAddr_i,
   input  cpu_pkg::instrT     hostWdata_i,
   output logic               hostAck_o,
   output cpu_pkg::dataT      hostRdata_o,
   output logic               imemWe_o,
   output cpu_pkg::imemAddrT  imemAddr_o,
   output cpu_pkg::instrT     imemWdata_o,
   output cpu_pkg::regIdxT    dbgRegIdx_o,
   input  cpu_pkg::dataT      dbgRegData_i
);
   import cpu_pkg::*;

   // four-phase handshake tracking
   typedef enum logic [1:0] {IDLE, ACK, RELEASE} hostStateT;

   hostStateT state;
   logic      accept;

   // a new request is only taken from idle
   assign accept = (state == IDLE) && hostReq_i;

   // imem write fires on the accepting cycle only
   assign imemWe_o    = accept && hostWe_i;
   assign imemAddr_o  = hostAddr_i;
   assign imemWdata_o = hostWdata_i;

   // low address bits pick the register on reads
   assign dbgRegIdx_o = regIdxT'(hostAddr_i);

   // ack is high for the whole acknowledge phase
   assign hostAck_o = (state == ACK);

   always_ff @(posedge clock or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (hostReq_i)
               begin
                  state <= ACK;
               end
            end
            // hold until the host drops req
            ACK:
            begin
               if (!hostReq_i)
               begin
                  state <= RELEASE;
               end
            end
            // one quiet cycle with ack low
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // read data captured once, stays put while ack is up
   always_ff @(posedge clock)
   begin
      if (accept && !hostWe_i)
      begin
         hostRdata_o <= dbgRegData_i;
      end
   end

endmodule

//--- verilog/fetchUnit.sv
`include "cpu_consts.svh"

module fetchUnit
(
   input  logic               clock,
   input  logic               rstN_i,
   input  logic               run_i,
   input  logic               imemWe_i,
   input  cpu_pkg::imemAddrT  imemAddr_i,
   input  cpu_pkg::instrT     imemWdata_i,
   output cpu_pkg::instrT     instr_o,
   output logic               valid_o
);
   import cpu_pkg::*;

   instrT    imem [`IMEM_DEPTH];
   imemAddrT pc;
   instrT    fetched;
   logic     isHalt;
   // set once HALT has been fetched
   logic     fetchStopped;

   // host write port into instruction memory
   always_ff @(posedge clock)
   begin
      if (imemWe_i)
      begin
         imem[imemAddr_i] <= imemWdata_i;
      end
   end

   // async read at the pc
   assign fetched = imem[pc];

   // halt spotted right at fetch
   assign isHalt = (opcodeT'(fetched[`OP_HI:`OP_LO]) == HALT);

   always_ff @(posedge clock or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         pc           <= imemAddrT'(`RESET_VALUE);
         fetchStopped <= 1'b0;
         valid_o      <= 1'b0;
      end
      else if (!run_i)
      begin
         // parked at word 0 while the host owns the core
         pc           <= imemAddrT'(`RESET_VALUE);
         fetchStopped <= 1'b0;
         valid_o      <= 1'b0;
      end
      else if (fetchStopped)
      begin
         // bubbles after HALT
         valid_o <= 1'b0;
      end
      else
      begin
         valid_o      <= 1'b1;
         fetchStopped <= isHalt;
         // pc freezes on HALT
         if (!isHalt)
         begin
            pc <= pc + imemAddrT'(1);
         end
      end
   end

   // fetch/decode instruction register
   always_ff @(posedge clock)
   begin
      if (run_i && !fetchStopped)
      begin
         instr_o <= fetched;
      end
   end

endmodule

//--- verilog/decodeUnit.sv
`include "cpu_consts.svh"

module decodeUnit
(
   input  logic              clock,
   input  logic              rstN_i,
   input  logic              run_i,
   input  cpu_pkg::instrT    instr_i,
   input  logic              valid_i,
   input  logic              wbValid_i,
   input  cpu_pkg::regIdxT   wbRd_i,
   input  cpu_pkg::dataT     wbData_i,
   input  cpu_pkg::regIdxT   dbgRegIdx_i,
   output cpu_pkg::dataT     dbgRegData_o,
   output cpu_pkg::opcodeT   exOp_o,
   output cpu_pkg::dataT     exA_o,
   output cpu_pkg::dataT     exB_o,
   output cpu_pkg::dataT     exImm_o,
   output cpu_pkg::regIdxT   exRd_o,
   output cpu_pkg::regIdxT   exRn_o,
   output cpu_pkg::regIdxT   exRm_o,
   output logic              exValid_o
);
   import cpu_pkg::*;

   localparam int ImmBits = `IMM_HI - `IMM_LO + 1;

   dataT   regs [`NUM_REGS];
   opcodeT decOp;
   regIdxT rd;
   regIdxT rn;
   regIdxT rm;
   dataT   immExt;
   dataT   readA;
   dataT   readB;

   // read port with write bypass, new data wins in the same cycle
   function automatic dataT readReg(input regIdxT idx);
      dataT value;
      value = regs[idx];
      if (wbValid_i && (wbRd_i == idx))
      begin
         value = wbData_i;
      end
      return value;
   endfunction

   // register file written from the writeback bundle
   always_ff @(posedge clock or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         for (int i = 0; i < `NUM_REGS; i++)
         begin
            regs[i] <= dataT'(`RESET_VALUE);
         end
      end
      else if (wbValid_i)
      begin
         regs[wbRd_i] <= wbData_i;
      end
   end

   // field split
   assign rd = instr_i[`RD_HI:`RD_LO];
   assign rn = instr_i[`RN_HI:`RN_LO];
   assign rm = instr_i[`RM_HI:`RM_LO];

   // sign-extended 16-bit immediate
   assign immExt = {{(`DATA_WIDTH-ImmBits){instr_i[`IMM_HI]}}, instr_i[`IMM_HI:`IMM_LO]};

   // unknown codes fold to NOP
   always_comb
   begin
      case (opcodeT'(instr_i[`OP_HI:`OP_LO]))
         ADD, SUB, AND, ORR, EOR, ADDI, MOVI, HALT:
         begin
            decOp = opcodeT'(instr_i[`OP_HI:`OP_LO]);
         end
         default:
         begin
            decOp = NOP;
         end
      endcase
   end

   // two operand ports plus the host debug port
   always_comb
   begin
      readA        = readReg(rn);
      readB        = readReg(rm);
      dbgRegData_o = readReg(dbgRegIdx_i);
   end

   // decode/execute valid, flushed while stopped
   always_ff @(posedge clock or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         exValid_o <= 1'b0;
      end
      else
      begin
         exValid_o <= valid_i && run_i;
      end
   end

   // decode/execute payload
   always_ff @(posedge clock)
   begin
      exOp_o  <= decOp;
      exA_o   <= readA;
      exB_o   <= readB;
      exImm_o <= immExt;
      exRd_o  <= rd;
      exRn_o  <= rn;
      exRm_o  <= rm;
   end

endmodule

//--- verilog/executeUnit.sv
module executeUnit
(
   input  logic              clock,
   input  logic              rstN_i,
   input  logic              run_i,
   input  cpu_pkg::opcodeT   exOp_i,
   input  cpu_pkg::dataT     exA_i,
   input  cpu_pkg::dataT     exB_i,
   input  cpu_pkg::dataT     exImm_i,
   input  cpu_pkg::regIdxT   exRd_i,
   input  cpu_pkg::regIdxT   exRn_i,
   input  cpu_pkg::regIdxT   exRm_i,
   input  logic              exValid_i,
   output logic              wbValid_o,
   output cpu_pkg::regIdxT   wbRd_o,
   output cpu_pkg::dataT     wbData_o,
   output logic              halted_o
);
   import cpu_pkg::*;

   dataT opA;
   dataT opB;
   dataT aluResult;
   logic writesReg;

   // forward the previous result into either operand
   // wbValid_o is only set by writing opcodes
   always_comb
   begin
      opA = exA_i;
      opB = exB_i;
      if (wbValid_o && (wbRd_o == exRn_i))
      begin
         opA = wbData_o;
      end
      if (wbValid_o && (wbRd_o == exRm_i))
      begin
         opB = wbData_o;
      end
   end

   // alu, wraps mod 2^32
   always_comb
   begin
      aluResult = '0;
      writesReg = 1'b1;
      case (exOp_i)
         ADD:
         begin
            aluResult = opA + opB;
         end
         SUB:
         begin
            aluResult = opA - opB;
         end
         AND:
         begin
            aluResult = opA & opB;
         end
         ORR:
         begin
            aluResult = opA | opB;
         end
         EOR:
         begin
            aluResult = opA ^ opB;
         end
         ADDI:
         begin
            aluResult = opA + exImm_i;
         end
         MOVI:
         begin
            aluResult = exImm_i;
         end
         // NOP and HALT leave the registers alone
         default:
         begin
            writesReg = 1'b0;
         end
      endcase
   end

   // execute/writeback control and sticky halt
   always_ff @(posedge clock or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         wbValid_o <= 1'b0;
         halted_o  <= 1'b0;
      end
      else if (!run_i)
      begin
         wbValid_o <= 1'b0;
         halted_o  <= 1'b0;
      end
      else
      begin
         wbValid_o <= exValid_i && writesReg;
         // rises as HALT leaves execute
         if (exValid_i && (exOp_i == HALT))
         begin
            halted_o <= 1'b1;
         end
      end
   end

   // writeback payload
   always_ff @(posedge clock)
   begin
      wbRd_o   <= exRd_i;
      wbData_o <= aluResult;
   end

endmodule

//--- verilog/cpuTop.sv
module cpuTop
(
   input  logic               clock,
   input  logic               rstN_i,
   input  logic               run_i,
   input  logic               hostReq_i,
   input  logic               hostWe_i,
   input  cpu_pkg::imemAddrT  hostAddr_i,
   input  cpu_pkg::instrT     hostWdata_i,
   output logic               hostAck_o,
   output cpu_pkg::dataT      hostRdata_o,
   output logic               halted_o
);
   import cpu_pkg::*;

   // host to fetch
   logic     imemWe;
   imemAddrT imemAddr;
   instrT    imemWdata;

   // host debug read of the register file
   regIdxT   dbgRegIdx;
   dataT     dbgRegData;

   // fetch/decode
   instrT    fetchInstr;
   logic     fetchValid;

   // decode/execute
   opcodeT   exOp;
   dataT     exA;
   dataT     exB;
   dataT     exImm;
   regIdxT   exRd;
   regIdxT   exRn;
   regIdxT   exRm;
   logic     exValid;

   // writeback bundle, back to the register file
   logic     wbValid;
   regIdxT   wbRd;
   dataT     wbData;

   hostPort
   host
   (
      .clock        (clock       ),
      .rstN_i       (rstN_i      ),
      .hostReq_i    (hostReq_i   ),
      .hostWe_i     (hostWe_i    ),
      .hostAddr_i   (hostAddr_i  ),
      .hostWdata_i  (hostWdata_i ),
      .hostAck_o    (hostAck_o   ),
      .hostRdata_o  (hostRdata_o ),
      .imemWe_o     (imemWe      ),
      .imemAddr_o   (imemAddr    ),
      .imemWdata_o  (imemWdata   ),
      .dbgRegIdx_o  (dbgRegIdx   ),
      .dbgRegData_i (dbgRegData  )
   );

   fetchUnit
   fetch
   (
      .clock        (clock       ),
      .rstN_i       (rstN_i      ),
      .run_i        (run_i       ),
      .imemWe_i     (imemWe      ),
      .imemAddr_i   (imemAddr    ),
      .imemWdata_i  (imemWdata   ),
      .instr_o      (fetchInstr  ),
      .valid_o      (fetchValid  )
   );

   decodeUnit
   decode
   (
      .clock        (clock       ),
      .rstN_i       (rstN_i      ),
      .run_i        (run_i       ),
      .instr_i      (fetchInstr  ),
      .valid_i      (fetchValid  ),
      .wbValid_i    (wbValid     ),
      .wbRd_i       (wbRd        ),
      .wbData_i     (wbData      ),
      .dbgRegIdx_i  (dbgRegIdx   ),
      .dbgRegData_o (dbgRegData  ),
      .exOp_o       (exOp        ),
      .exA_o        (exA         ),
      .exB_o        (exB         ),
      .exImm_o      (exImm       ),
      .exRd_o       (exRd        ),
      .exRn_o       (exRn        ),
      .exRm_o       (exRm        ),
      .exValid_o    (exValid     )
   );

   executeUnit
   execute
   (
      .clock        (clock       ),
      .rstN_i       (rstN_i      ),
      .run_i        (run_i       ),
      .exOp_i       (exOp        ),
      .exA_i        (exA         ),
      .exB_i        (exB         ),
      .exImm_i      (exImm       ),
      .exRd_i       (exRd        ),
      .exRn_i       (exRn        ),
      .exRm_i       (exRm        ),
      .exValid_i    (exValid     ),
      .wbValid_o    (wbValid     ),
      .wbRd_o       (wbRd        ),
      .wbData_o     (wbData      ),
      .halted_o     (halted_o    )
   );

endmodule

//--- test/tbClock.sv
module tbClock
(
   output logic clock_o
);

   // 100 unit period
   initial
   begin
      clock_o = 1'b0;
   end

   always #50 clock_o = ~clock_o;

endmodule

//--- test/cpu_assertions.sv
module cpuAssertions
(
   input logic          clock,
   input logic          rstN_i,
   input logic          hostReq_i,
   input logic          hostAck_i,
   input cpu_pkg::dataT hostRdata_i
);

   // ack only ever rises in answer to a request
   ackNeedsReq: assert property (@(posedge clock) disable iff (!rstN_i)
      $rose(hostAck_i) |-> $past(hostReq_i))
      else $error("host ack rose with no request pending");

   // ack held as long as the host keeps req up
   ackHeld: assert property (@(posedge clock) disable iff (!rstN_i)
      (hostAck_i && hostReq_i) |=> hostAck_i)
      else $error("host ack dropped while request still high");

   // read data frozen during the acknowledge phase
   rdataStable: assert property (@(posedge clock) disable iff (!rstN_i)
      hostAck_i |=> (!hostAck_i || $stable(hostRdata_i)))
      else $error("host read data changed while ack high");

endmodule

bind hostPort cpuAssertions hostChecks
(
   .clock       (clock      ),
   .rstN_i      (rstN_i     ),
   .hostReq_i   (hostReq_i  ),
   .hostAck_i   (hostAck_o  ),
   .hostRdata_i (hostRdata_o)
);

//--- test/cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb;
   import cpu_pkg::*;

   // run sizes, used for the cycle limit
   localparam int NumRandom     = 3;
   localparam int RandomLen     = 40;
   localparam int DirectedWords = 22;
   localparam int NumRuns       = NumRandom + 4;
   localparam int ProgWords     = NumRandom * (RandomLen + 1) + DirectedWords;
   localparam int Handshakes    = ProgWords + NumRuns * `NUM_REGS;
   localparam int CycleLimit    = Handshakes * 8 + ProgWords + 16 + 400;

   logic     clock;
   logic     rstN;
   logic     run;
   logic     hostReq;
   logic     hostWe;
   imemAddrT hostAddr;
   instrT    hostWdata;
   logic     hostAck;
   dataT     hostRdata;
   logic     halted;

   integer   seed;
   int       cycleCount = 0;
   instrT    prog [$];
   // reference register file, carried across runs like the core
   dataT     modelRegs [`NUM_REGS];

   tbClock clockGen
   (
      .clock_o (clock)
   );

   cpuTop dut
   (
      .clock       (clock    ),
      .rstN_i      (rstN     ),
      .run_i       (run      ),
      .hostReq_i   (hostReq  ),
      .hostWe_i    (hostWe   ),
      .hostAddr_i  (hostAddr ),
      .hostWdata_i (hostWdata),
      .hostAck_o   (hostAck  ),
      .hostRdata_o (hostRdata),
      .halted_o    (halted   )
   );

   task automatic abortRun();
      $display("=== FAIL ===");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic checkReg(input string name, input dataT expected, input dataT actual);
      if (actual !== expected)
      begin
         $display("Error %s: expected %h, actual %h", name, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("Error %s: expected %b, actual %b", name, expected, actual);
         abortRun();
      end
   endtask

   // op | rd | rn | rm | imm
   function automatic instrT encode(input logic [3:0] op, input regIdxT rd, input regIdxT rn,
                                    input regIdxT rm, input logic [15:0] imm);
      return {op, rd, rn, rm, imm};
   endfunction

   // one full four-phase transfer
   task automatic hostTransfer(input logic we, input imemAddrT addr, input instrT wdata,
                               output dataT rdata);
      @(posedge clock);
      hostReq   <= 1'b1;
      hostWe    <= we;
      hostAddr  <= addr;
      hostWdata <= wdata;
      do
         @(negedge clock);
      while (hostAck !== 1'b1);
      rdata = hostRdata;
      @(posedge clock);
      hostReq <= 1'b0;
      do
         @(negedge clock);
      while (hostAck !== 1'b0);
   endtask

   // sequential execution up to the first HALT
   task automatic executeModel();
      logic [3:0] op;
      dataT       a;
      dataT       b;
      dataT       imm;
      regIdxT     rd;
      foreach (prog[i])
      begin
         op  = prog[i][31:28];
         rd  = prog[i][27:24];
         a   = modelRegs[prog[i][23:20]];
         b   = modelRegs[prog[i][19:16]];
         imm = {{16{prog[i][15]}}, prog[i][15:0]};
         if (op == HALT)
         begin
            break;
         end
         case (op)
            ADD:  modelRegs[rd] = a + b;
            SUB:  modelRegs[rd] = a - b;
            AND:  modelRegs[rd] = a & b;
            ORR:  modelRegs[rd] = a | b;
            EOR:  modelRegs[rd] = a ^ b;
            ADDI: modelRegs[rd] = a + imm;
            MOVI: modelRegs[rd] = imm;
            // NOP and unused codes
            default:
            begin
            end
         endcase
      end
   endtask

   // load, run to halt, read back all registers, stop the core
   task automatic runProgram(input string name);
      dataT value;
      foreach (prog[i])
      begin
         hostTransfer(1'b1, imemAddrT'(i), prog[i], value);
      end
      checkFlag({name, " halted before run"}, 1'b0, halted);
      @(posedge clock);
      run <= 1'b1;
      do
         @(negedge clock);
      while (halted !== 1'b1);
      executeModel();
      for (int r = 0; r < `NUM_REGS; r++)
      begin
         hostTransfer(1'b0, imemAddrT'(r), '0, value);
         checkReg($sformatf("%s r%0d", name, r), modelRegs[r], value);
      end
      checkFlag({name, " halted after reads"}, 1'b1, halted);
      // halt flag clears one edge after run drops
      @(posedge clock);
      run <= 1'b0;
      @(posedge clock);
      @(negedge clock);
      checkFlag({name, " halted after run low"}, 1'b0, halted);
   endtask

   always @(posedge clock)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
         $display("=== FAIL ===");
         $fatal(1, "cycle limit reached");
      end
   end

   initial
   begin
      integer r;
      rstN      <= 1'b0;
      run       <= 1'b0;
      hostReq   <= 1'b0;
      hostWe    <= 1'b0;
      hostAddr  <= '0;
      hostWdata <= '0;
      seed = 32'hbb5;
      for (int i = 0; i < `NUM_REGS; i++)
      begin
         modelRegs[i] = '0;
      end

      repeat (16) @(posedge clock);
      rstN <= 1'b1;
      @(negedge clock);
      checkFlag("reset ack", 1'b0, hostAck);
      checkFlag("reset halted", 1'b0, halted);

      // random opcodes 0..7, HALT at the end
      for (int p = 0; p < NumRandom; p++)
      begin
         prog.delete();
         for (int i = 0; i < RandomLen; i++)
         begin
            r = $random(seed);
            prog.push_back(encode({1'b0, r[2:0]}, r[7:4], r[11:8], r[15:12], r[31:16]));
         end
         prog.push_back(encode(HALT, 4'd0, 4'd0, 4'd0, 16'h0000));
         runProgram($sformatf("random%0d", p));
      end

      // every instruction reads the rd just before it
      prog.delete();
      prog.push_back(encode(MOVI, 4'd1, 4'd0, 4'd0, 16'h0007));
      prog.push_back(encode(ADD,  4'd2, 4'd1, 4'd1, 16'h0000));
      prog.push_back(encode(ADD,  4'd3, 4'd2, 4'd2, 16'h0000));
      prog.push_back(encode(SUB,  4'd4, 4'd3, 4'd1, 16'h0000));
      prog.push_back(encode(ADDI, 4'd5, 4'd4, 4'd0, 16'hfffd));
      prog.push_back(encode(ORR,  4'd6, 4'd2, 4'd5, 16'h0000));
      prog.push_back(encode(HALT, 4'd0, 4'd0, 4'd0, 16'h0000));
      runProgram("backToBack");

      // reads two slots after the write hit the regfile bypass
      prog.delete();
      prog.push_back(encode(MOVI, 4'd7,  4'd0,  4'd0, 16'h1234));
      prog.push_back(encode(MOVI, 4'd8,  4'd0,  4'd0, 16'h8001));
      prog.push_back(encode(ADD,  4'd9,  4'd7,  4'd7, 16'h0000));
      prog.push_back(encode(ORR,  4'd10, 4'd8,  4'd0, 16'h0000));
      prog.push_back(encode(NOP,  4'd0,  4'd0,  4'd0, 16'h0000));
      prog.push_back(encode(EOR,  4'd11, 4'd10, 4'd9, 16'h0000));
      prog.push_back(encode(HALT, 4'd0,  4'd0,  4'd0, 16'h0000));
      runProgram("distanceTwo");

      // words after HALT must not retire
      prog.delete();
      prog.push_back(encode(MOVI, 4'd12, 4'd0,  4'd0,  16'h00c3));
      prog.push_back(encode(HALT, 4'd0,  4'd0,  4'd0,  16'h0000));
      prog.push_back(encode(MOVI, 4'd12, 4'd0,  4'd0,  16'h0099));
      prog.push_back(encode(MOVI, 4'd13, 4'd0,  4'd0,  16'h0077));
      prog.push_back(encode(ADD,  4'd14, 4'd12, 4'd12, 16'h0000));
      runProgram("haltStop");

      // second run on the registers left behind
      prog.delete();
      prog.push_back(encode(ADD,  4'd15, 4'd12, 4'd12, 16'h0000));
      prog.push_back(encode(ADDI, 4'd13, 4'd15, 4'd0,  16'h0001));
      prog.push_back(encode(HALT, 4'd0,  4'd0,  4'd0,  16'h0000));
      runProgram("reRun");

      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- flist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/hostPort.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/cpuTop.sv
test/tbClock.sv
test/cpu_assertions.sv
test/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f flist.f --top-module cpu_tb -o cpu_sim

# the verdict comes from the printed output, not the exit code
output=$(./obj_dir/cpu_sim 2>&1) || true
echo "$output"

if grep -qF "=== PASS ===" <<< "$output"; then
   exit 0
else
   exit 1
fi
